//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fadd_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := test failed
PASS_MSG  := test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/fadd_tb_model.svh
// fadd reference model: exact aligned sums, directed rounding by neighbour steps, and the LCG
`ifndef FADD_TB_MODEL_SVH
`define FADD_TB_MODEL_SVH

function automatic logic [31:0] lcg_step(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// signed integer value of a double in units of the lowest fraction bit at exponent e0
function automatic logic signed [127:0] aligned_int(input fp_word_t x, input int e0);
  logic signed [127:0] m;
  int                  e;
  e = int'(x[62:52]);
  if (e == 0) return '0;
  m = {75'd0, 1'b1, x[51:0]};
  if (e >= e0) begin
    m = m <<< (e - e0);
  end else begin
    m = m >>> (e0 - e);
  end
  return x[63] ? -m : m;
endfunction

// neighbouring double toward plus or minus infinity
function automatic fp_word_t step_toward(input fp_word_t x, input logic up);
  if (up ^ x[63]) return x + 64'd1;
  return x - 64'd1;
endfunction

// expected sum of two normal operands
function automatic fp_word_t model_add(input fp_word_t x, input fp_word_t y, input logic s,
                                       input fadd_rmode_t rm, output logic inexact);
  fp_word_t            ye;
  fp_word_t            near;
  int                  e0;
  logic signed [127:0] s_int;
  logic signed [127:0] r_int;
  logic                up;
  ye    = {y[63] ^ s, y[62:0]};
  near  = $realtobits($bitstoreal(x) + $bitstoreal(ye));
  e0    = (x[62:52] < ye[62:52]) ? int'(x[62:52]) : int'(ye[62:52]);
  s_int = aligned_int(x, e0) + aligned_int(ye, e0);
  r_int = aligned_int(near, e0);
  inexact = (r_int != s_int);
  if (s_int == 0) return {rm == `FADD_RM_MINUS, 63'd0};
  if (!inexact) return near;
  case (rm)
    `FADD_RM_TRUNC: up = (s_int < 0);
    `FADD_RM_PLUS:  up = 1'b1;
    `FADD_RM_MINUS: up = 1'b0;
    default:        return near;
  endcase
  // nearest already on the wanted side of the exact sum
  if (up == (r_int > s_int)) return near;
  return step_toward(near, up);
endfunction

`endif

//--- dv/fadd_tb.sv
// fadd testbench: random and directed sums checked in issue order against a reference model
`timescale 1ns/1ps
`include "fadd_cfg.svh"

module fadd_tb import fadd_pkg::*; ();

  localparam int RANDOM_ITEMS = 300;
  localparam int DRAIN_LIMIT  = 40;

  logic        clk;
  logic        rst;
  logic        en;
  fp_word_t    a;
  fp_word_t    b;
  logic        sub;
  fadd_rmode_t rmode;
  fp_word_t    res;
  logic        res_valid;
  fadd_flags_t raise;
  logic [2:0]  raise_bits;

  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  int          errors;
  int          check_errors = 0;
  int          issued;
  int          received = 0;
  logic        timed_out;

  // one entry per item in flight
  string       name_q[$];
  fp_word_t    want_q[$];
  logic [2:0]  flags_q[$];
  int          issue_q[$];

  `include "fadd_tb_model.svh"

  assign raise_bits = raise;

  fadd_top fadd_top_i (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .a         (a),
    .b         (b),
    .sub       (sub),
    .rmode     (rmode),
    .res       (res),
    .res_valid (res_valid),
    .raise     (raise)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] rand32();
    lcg_state = lcg_step(lcg_state);
    return lcg_state;
  endfunction

  function automatic fp_word_t rand_operand(input int exp_b);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    r1 = rand32();
    r2 = rand32();
    r3 = rand32();
    return {r3[31], 11'(exp_b), r1[31:8], r2[31:8], r3[30:27]};
  endfunction

  // code 5 is one of the unused ones
  function automatic fadd_rmode_t rmode_from(input int k);
    case (k)
      0:       return `FADD_RM_TRUNC;
      1:       return `FADD_RM_EVEN;
      2:       return `FADD_RM_PLUS;
      3:       return `FADD_RM_MINUS;
      default: return 3'd5;
    endcase
  endfunction

  function automatic string mode_name(input fadd_rmode_t rm);
    case (rm)
      `FADD_RM_TRUNC: return "random_trunc";
      `FADD_RM_EVEN:  return "random_even";
      `FADD_RM_PLUS:  return "random_plus";
      `FADD_RM_MINUS: return "random_minus";
      default:        return "random_unused";
    endcase
  endfunction

  task automatic issue(input string name, input fp_word_t x, input fp_word_t y, input logic s,
                       input fadd_rmode_t rm, input fp_word_t want, input logic [2:0] want_flags);
    en    = 1'b1;
    a     = x;
    b     = y;
    sub   = s;
    rmode = rm;
    name_q.push_back(name);
    want_q.push_back(want);
    flags_q.push_back(want_flags);
    issue_q.push_back(cycle_cnt + 1);
    issued++;
    @(posedge clk);
    #1;
    en = 1'b0;
  endtask

  task automatic wait_drain(input string phase);
    int n;
    n = 0;
    while (want_q.size() != 0 && n < DRAIN_LIMIT && !timed_out) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (want_q.size() != 0 && !timed_out) begin
      $display("timeout: %s results still missing after %0d cycles", phase, DRAIN_LIMIT);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // back to back with en held high
  task automatic run_random();
    fp_word_t    x;
    fp_word_t    y;
    fp_word_t    want;
    fadd_rmode_t rm;
    logic        inexact;
    logic [31:0] r;
    logic [31:0] r2;
    int          ea;
    int          eb;
    for (int i = 0; i < RANDOM_ITEMS; i++) begin
      r  = rand32();
      r2 = rand32();
      ea = 900 + int'(r[31:24]);
      // some close exponents for heavy cancellation
      if (r2[22:21] == 2'b00) begin
        eb = ea + int'(r[23:22]) - 1;
      end else begin
        eb = ea + (int'(r[23:16]) % 121) - 60;
      end
      x    = rand_operand(ea);
      y    = rand_operand(eb);
      rm   = rmode_from(int'(r2[30:23]) % 5);
      want = model_add(x, y, r2[31], rm, inexact);
      issue(mode_name(rm), x, y, r2[31], rm, want, {2'b00, inexact});
    end
  endtask

  task automatic run_directed();
    fp_word_t fmax;
    fp_word_t nmax;
    fp_word_t pinf;
    fp_word_t one;
    fp_word_t pi;
    fmax = {1'b0, 11'(`FADD_EXP_MAX), {52{1'b1}}};
    nmax = {1'b1, fmax[62:0]};
    pinf = {1'b0, 11'h7FF, 52'd0};
    one  = 64'h3FF0_0000_0000_0000;
    pi   = 64'h4009_21FB_5444_2D18;
    issue("nan_quiet", 64'h7FF8_0000_0000_0000, one, 1'b0, `FADD_RM_EVEN, `FADD_QNAN, 3'b000);
    issue("nan_signaling", one, 64'h7FF0_0000_0000_0001, 1'b0, `FADD_RM_EVEN,
          `FADD_QNAN, 3'b100);
    issue("inf_minus_inf", pinf, pinf, 1'b1, `FADD_RM_EVEN, `FADD_QNAN, 3'b100);
    issue("inf_plus_finite", pinf, one, 1'b0, `FADD_RM_TRUNC, pinf, 3'b000);
    issue("finite_minus_inf", one, pinf, 1'b1, `FADD_RM_EVEN, {1'b1, pinf[62:0]}, 3'b000);
    issue("x_minus_x_even", pi, pi, 1'b1, `FADD_RM_EVEN, 64'd0, 3'b000);
    issue("x_minus_x_minus", pi, pi, 1'b1, `FADD_RM_MINUS, 64'h8000_0000_0000_0000, 3'b000);
    issue("overflow_even", fmax, fmax, 1'b0, `FADD_RM_EVEN, pinf, 3'b011);
    issue("overflow_trunc", fmax, fmax, 1'b0, `FADD_RM_TRUNC, fmax, 3'b011);
    issue("overflow_neg_plus", nmax, nmax, 1'b0, `FADD_RM_PLUS, nmax, 3'b011);
  endtask

  // outputs sampled mid-cycle, in issue order
  always @(negedge clk) begin : check_results
    string      name;
    fp_word_t   want;
    logic [2:0] want_flags;
    int         age;
    if (!rst && res_valid) begin
      assert (want_q.size() != 0) else begin
        $display("res_valid high with no item in flight at cycle %0d", cycle_cnt);
        check_errors++;
      end
      if (want_q.size() != 0) begin
        name       = name_q.pop_front();
        want       = want_q.pop_front();
        want_flags = flags_q.pop_front();
        age        = cycle_cnt - issue_q.pop_front();
        received++;
        assert (res === want) else begin
          $display("[FAIL] %s result expected %h actual %h", name, want, res);
          check_errors++;
        end
        assert (raise_bits === want_flags) else begin
          $display("[FAIL] %s flags expected %b actual %b", name, want_flags, raise_bits);
          check_errors++;
        end
        assert (age == 3) else begin
          $display("[FAIL] %s latency expected 3 actual %0d", name, age);
          check_errors++;
        end
      end
    end else if (!rst && issue_q.size() != 0) begin
      assert (cycle_cnt - issue_q[0] < 3) else begin
        $display("no res_valid for %s by cycle %0d", name_q[0], cycle_cnt);
        check_errors++;
        name_q.delete(0);
        want_q.delete(0);
        flags_q.delete(0);
        issue_q.delete(0);
      end
    end
  end

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    en        = 1'b0;
    a         = '0;
    b         = '0;
    sub       = 1'b0;
    rmode     = `FADD_RM_EVEN;
    lcg_state = 32'd42;
    errors    = 0;
    issued    = 0;
    timed_out = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    // pipe stays idle before the first item
    repeat (6) @(posedge clk);
    #1;
    run_random();
    wait_drain("random");
    run_directed();
    wait_drain("directed");
    assert (received == issued) else begin
      $display("result count mismatch, %0d issued and %0d received", issued, received);
      errors++;
    end
    $display("errors %0d, check errors %0d, items issued %0d, results received %0d",
             errors + check_errors, check_errors, issued, received);
    if (errors + check_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+source
+incdir+dv
source/fadd_pkg.sv
source/fadd_align.sv
source/fadd_sum.sv
source/fadd_round.sv
source/fadd_top.sv
dv/fadd_tb.sv

//--- source/fadd_align.sv
// fadd align stage: unpacks both operands, detects special values, swaps and aligns
`timescale 1ns/1ps
`include "fadd_cfg.svh"

module fadd_align import fadd_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        en,
  input  fp_word_t    a,
  input  fp_word_t    b,
  input  logic        sub,
  input  fadd_rmode_t rmode,
  output logic        s1_valid,
  output logic        s1_sign,
  output fadd_exp_t   s1_exp,
  output fadd_mant_t  s1_big,
  output fadd_mant_t  s1_small,
  output logic        s1_sticky,
  output logic        s1_eff_sub,
  output fadd_rmode_t s1_rmode,
  output logic        s1_spec,
  output fp_word_t    s1_spec_word,
  output logic        s1_spec_invalid
);

  localparam int WW = `FADD_WORD_W;
  localparam int FW = `FADD_FRAC_W;
  localparam int EW = `FADD_EXP_W;
  localparam int MW = `FADD_MANT_W;

  logic             en_q;
  fp_word_t         a_q;
  fp_word_t         b_q;
  logic             sub_q;
  fadd_rmode_t      rmode_q;
  logic             a_sign;
  logic             b_sign;
  logic [EW-1:0]    a_exp;
  logic [EW-1:0]    b_exp;
  logic [FW-1:0]    a_frac;
  logic [FW-1:0]    b_frac;
  logic             a_zero;
  logic             b_zero;
  logic             a_inf;
  logic             b_inf;
  logic             a_nan;
  logic             b_nan;
  fadd_mant_t       a_mant;
  fadd_mant_t       b_mant;
  logic             a_ge_b;
  logic             eff_sub;
  logic [EW-1:0]    big_exp;
  logic [EW-1:0]    exp_diff;
  logic [6:0]       shamt;
  fadd_mant_t       small_mant;
  logic [2*MW-1:0]  shift_wide;
  logic             spec;
  logic             spec_invalid;
  fp_word_t         spec_word;

  // denormals flush to zero here
  function automatic fadd_mant_t unpack_mant(input logic [EW-1:0] e, input logic [FW-1:0] f);
    unpack_mant = (e == '0) ? '0 : {1'b0, 1'b1, f, 2'b00};
  endfunction

  // input capture
  always_ff @(posedge clk) begin
    if (rst) begin
      en_q <= 1'b0;
    end else begin
      en_q <= en;
    end
  end

  always_ff @(posedge clk) begin
    a_q     <= a;
    b_q     <= b;
    sub_q   <= sub;
    rmode_q <= rmode;
  end

  // b sign folds in the subtract
  assign a_sign = a_q[WW-1];
  assign b_sign = b_q[WW-1] ^ sub_q;
  assign a_exp  = a_q[WW-2 -: EW];
  assign b_exp  = b_q[WW-2 -: EW];
  assign a_frac = a_q[FW-1:0];
  assign b_frac = b_q[FW-1:0];

  assign a_zero = (a_exp == '0);
  assign b_zero = (b_exp == '0);
  assign a_inf  = (&a_exp) && (a_frac == '0);
  assign b_inf  = (&b_exp) && (b_frac == '0);
  assign a_nan  = (&a_exp) && (a_frac != '0);
  assign b_nan  = (&b_exp) && (b_frac != '0);

  assign a_mant  = unpack_mant(a_exp, a_frac);
  assign b_mant  = unpack_mant(b_exp, b_frac);
  assign eff_sub = a_sign ^ b_sign;

  // magnitude compare, exponent first
  assign a_ge_b     = {a_exp, a_mant} >= {b_exp, b_mant};
  assign big_exp    = a_ge_b ? a_exp : b_exp;
  assign small_mant = a_ge_b ? b_mant : a_mant;
  assign exp_diff   = a_ge_b ? (a_exp - b_exp) : (b_exp - a_exp);

  // past the mantissa width only sticky survives
  assign shamt      = (exp_diff >= EW'(MW)) ? 7'(MW) : exp_diff[6:0];
  assign shift_wide = {small_mant, {MW{1'b0}}} >> shamt;

  // nan wins, then inf minus inf, then a lone infinity
  assign spec = a_nan || b_nan || a_inf || b_inf || (a_zero && b_zero && !eff_sub);
  assign spec_invalid = (a_nan && !a_frac[FW-1]) || (b_nan && !b_frac[FW-1]) ||
                        (a_inf && b_inf && eff_sub);

  always_comb begin
    if (a_nan || b_nan || (a_inf && b_inf && eff_sub)) begin
      spec_word = `FADD_QNAN;
    end else if (a_inf) begin
      spec_word = {a_sign, {EW{1'b1}}, {FW{1'b0}}};
    end else if (b_inf) begin
      spec_word = {b_sign, {EW{1'b1}}, {FW{1'b0}}};
    end else begin
      // like-signed zeros keep their sign
      spec_word = {a_sign, {(WW-1){1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= en_q;
    end
  end

  always_ff @(posedge clk) begin
    s1_sign         <= a_ge_b ? a_sign : b_sign;
    s1_exp          <= fadd_exp_t'(big_exp);
    s1_big          <= a_ge_b ? a_mant : b_mant;
    s1_small        <= shift_wide[2*MW-1 -: MW];
    s1_sticky       <= |shift_wide[MW-1:0];
    s1_eff_sub      <= eff_sub;
    s1_rmode        <= rmode_q;
    s1_spec         <= spec;
    s1_spec_word    <= spec_word;
    s1_spec_invalid <= spec_invalid;
  end

  // swap must leave the aligned operand no larger than the big one
  a_small_le_big: assert property (@(posedge clk) disable iff (rst)
    s1_valid && !s1_spec |-> s1_small[MW-1:2] <= s1_big[MW-1:2]);

endmodule

//--- source/fadd_cfg.svh
// fadd configuration: double-precision field widths, exponent limits and rounding codes
`ifndef FADD_CFG_SVH
`define FADD_CFG_SVH

// raw IEEE double layout
`define FADD_WORD_W 64
`define FADD_FRAC_W 52
`define FADD_EXP_W 11

// working widths
// mantissa is overflow, hidden one, fraction, guard, round
`define FADD_MANT_W 56
// exponent with room for a carry and a borrow
`define FADD_XEXP_W 13

// largest biased exponent of a finite number
`define FADD_EXP_MAX 2046

// canonical quiet NaN returned for every NaN result
`define FADD_QNAN 64'h7FF8000000000001

// rounding mode codes
// 1, 5 and 6 are unused and round to nearest even
`define FADD_RM_TRUNC 3'd0
`define FADD_RM_EVEN 3'd2
`define FADD_RM_PLUS 3'd3
`define FADD_RM_MINUS 3'd4

`endif

//--- source/fadd_pkg.sv
// fadd types shared by the three pipeline stages and the top level
`include "fadd_cfg.svh"

package fadd_pkg;

  // raw operand or result word
  typedef logic [`FADD_WORD_W-1:0] fp_word_t;

  // working mantissa
  // [55] carry out of the add
  // [54] hidden one
  // [53:2] stored fraction
  // [1] guard, [0] round
  typedef logic [`FADD_MANT_W-1:0] fadd_mant_t;

  // biased exponent, read as two's complement once renormalised
  typedef logic [`FADD_XEXP_W-1:0] fadd_exp_t;

  // rounding mode code
  typedef logic [2:0] fadd_rmode_t;

  // exception flags raised with each result
  typedef struct packed {
    logic invalid;
    logic overflow;
    logic inexact;
  } fadd_flags_t;

endpackage

//--- source/fadd_round.sv
// fadd round stage that rounds the sum, packs the fields and applies special results and flags
`timescale 1ns/1ps
`include "fadd_cfg.svh"

module fadd_round import fadd_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        s2_valid,
  input  logic        s2_sign,
  input  fadd_exp_t   s2_exp,
  input  fadd_mant_t  s2_mant,
  input  logic        s2_sticky,
  input  logic        s2_zero,
  input  fadd_rmode_t s2_rmode,
  input  logic        s2_spec,
  input  fp_word_t    s2_spec_word,
  input  logic        s2_spec_invalid,
  output fp_word_t    res,
  output logic        res_valid,
  output fadd_flags_t raise
);

  localparam int WW = `FADD_WORD_W;
  localparam int FW = `FADD_FRAC_W;
  localparam int EW = `FADD_EXP_W;
  localparam int MW = `FADD_MANT_W;

  localparam fadd_exp_t EXP_MAX = fadd_exp_t'(`FADD_EXP_MAX);

  logic          lsb;
  logic          guard;
  logic          rest;
  logic          inexact;
  logic          inc;
  logic          is_trunc;
  logic          is_plus;
  logic          is_minus;
  logic          ovf;
  logic          unf;
  logic          ovf_to_inf;
  logic [FW+1:0] rnd;
  logic [FW-1:0] frac_r;
  fadd_exp_t     exp_r;
  fp_word_t      res_d;
  fadd_flags_t   raise_d;

  assign lsb     = s2_mant[2];
  assign guard   = s2_mant[1];
  assign rest    = s2_mant[0] | s2_sticky;
  assign inexact = guard | rest;

  assign is_trunc = (s2_rmode == `FADD_RM_TRUNC);
  assign is_plus  = (s2_rmode == `FADD_RM_PLUS);
  assign is_minus = (s2_rmode == `FADD_RM_MINUS);

  // unused codes fall to nearest even
  always_comb begin
    if (is_trunc) begin
      inc = 1'b0;
    end else if (is_plus) begin
      inc = !s2_sign && inexact;
    end else if (is_minus) begin
      inc = s2_sign && inexact;
    end else begin
      inc = guard && (rest || lsb);
    end
  end

  // a round carry leaves a zero fraction and bumps the exponent
  assign rnd    = {1'b0, s2_mant[MW-2:2]} + {{(FW+1){1'b0}}, inc};
  assign exp_r  = s2_exp + fadd_exp_t'(rnd[FW+1]);
  assign frac_r = rnd[FW-1:0];

  assign ovf = $signed(exp_r) > $signed(EXP_MAX);
  assign unf = $signed(exp_r) < $signed(fadd_exp_t'(1));

  // infinity unless the mode rounds toward zero for this sign
  assign ovf_to_inf = !(is_trunc || (is_plus && s2_sign) || (is_minus && !s2_sign));

  always_comb begin
    raise_d = '0;
    if (s2_spec) begin
      res_d           = s2_spec_word;
      raise_d.invalid = s2_spec_invalid;
    end else if (s2_zero) begin
      res_d = {is_minus, {(WW-1){1'b0}}};
    end else if (ovf) begin
      if (ovf_to_inf) begin
        res_d = {s2_sign, {EW{1'b1}}, {FW{1'b0}}};
      end else begin
        res_d = {s2_sign, EXP_MAX[EW-1:0], {FW{1'b1}}};
      end
      raise_d.overflow = 1'b1;
      raise_d.inexact  = 1'b1;
    end else if (unf) begin
      // flushed below min normal
      res_d           = {s2_sign, {(WW-1){1'b0}}};
      raise_d.inexact = 1'b1;
    end else begin
      res_d           = {s2_sign, exp_r[EW-1:0], frac_r};
      raise_d.inexact = inexact;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      raise     <= '0;
    end else begin
      res_valid <= s2_valid;
      raise     <= raise_d;
    end
  end

  always_ff @(posedge clk) begin
    res <= res_d;
  end

  // every result leaving the pipe is fully known
  a_res_known: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> !$isunknown(res));

endmodule

//--- source/fadd_sum.sv
// fadd sum stage: adds or subtracts the aligned mantissas and renormalises the result
`timescale 1ns/1ps
`include "fadd_cfg.svh"

module fadd_sum import fadd_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        s1_valid,
  input  logic        s1_sign,
  input  fadd_exp_t   s1_exp,
  input  fadd_mant_t  s1_big,
  input  fadd_mant_t  s1_small,
  input  logic        s1_sticky,
  input  logic        s1_eff_sub,
  input  fadd_rmode_t s1_rmode,
  input  logic        s1_spec,
  input  fp_word_t    s1_spec_word,
  input  logic        s1_spec_invalid,
  output logic        s2_valid,
  output logic        s2_sign,
  output fadd_exp_t   s2_exp,
  output fadd_mant_t  s2_mant,
  output logic        s2_sticky,
  output logic        s2_zero,
  output fadd_rmode_t s2_rmode,
  output logic        s2_spec,
  output fp_word_t    s2_spec_word,
  output logic        s2_spec_invalid
);

  localparam int MW  = `FADD_MANT_W;
  localparam int HID = MW - 2;

  fadd_mant_t raw;
  fadd_mant_t norm_mant;
  fadd_exp_t  norm_exp;
  logic       norm_sticky;
  logic [5:0] lead;

  // lost bits below the round position borrow one unit on subtract
  assign raw = s1_eff_sub ? (s1_big - s1_small - fadd_mant_t'(s1_sticky)) :
                            (s1_big + s1_small);

  // priority search, the highest set bit wins
  always_comb begin
    lead = '0;
    for (int i = 0; i < MW - 1; i++) begin
      if (raw[i]) begin
        lead = 6'(HID - i);
      end
    end
  end

  always_comb begin
    norm_mant   = raw;
    norm_exp    = s1_exp;
    norm_sticky = s1_sticky;
    if (raw[MW-1]) begin
      // carry out, one step right
      norm_mant   = raw >> 1;
      norm_exp    = s1_exp + 1'b1;
      norm_sticky = s1_sticky | raw[0];
    end else begin
      // may go below one after heavy cancellation
      norm_mant = raw << lead;
      norm_exp  = s1_exp - fadd_exp_t'(lead);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_sign         <= s1_sign;
    s2_exp          <= norm_exp;
    s2_mant         <= norm_mant;
    s2_sticky       <= norm_sticky;
    s2_zero         <= (raw == '0) && !s1_sticky;
    s2_rmode        <= s1_rmode;
    s2_spec         <= s1_spec;
    s2_spec_word    <= s1_spec_word;
    s2_spec_invalid <= s1_spec_invalid;
  end

  // any nonzero sum leaves the renormaliser with the hidden one in place
  a_hidden_set: assert property (@(posedge clk) disable iff (rst)
    s2_valid && !s2_zero |-> s2_mant[HID] && !s2_mant[MW-1]);

endmodule

//--- source/fadd_top.sv
// fadd top: three-stage double-precision adder built from align, sum and round stages
`timescale 1ns/1ps

module fadd_top import fadd_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        en,
  input  fp_word_t    a,
  input  fp_word_t    b,
  input  logic        sub,
  input  fadd_rmode_t rmode,
  output fp_word_t    res,
  output logic        res_valid,
  output fadd_flags_t raise
);

  // align to sum
  logic        s1_valid;
  logic        s1_sign;
  fadd_exp_t   s1_exp;
  fadd_mant_t  s1_big;
  fadd_mant_t  s1_small;
  logic        s1_sticky;
  logic        s1_eff_sub;
  fadd_rmode_t s1_rmode;
  logic        s1_spec;
  fp_word_t    s1_spec_word;
  logic        s1_spec_invalid;

  // sum to round
  logic        s2_valid;
  logic        s2_sign;
  fadd_exp_t   s2_exp;
  fadd_mant_t  s2_mant;
  logic        s2_sticky;
  logic        s2_zero;
  fadd_rmode_t s2_rmode;
  logic        s2_spec;
  fp_word_t    s2_spec_word;
  logic        s2_spec_invalid;

  fadd_align fadd_align_i (
    .clk             (clk),
    .rst             (rst),
    .en              (en),
    .a               (a),
    .b               (b),
    .sub             (sub),
    .rmode           (rmode),
    .s1_valid        (s1_valid),
    .s1_sign         (s1_sign),
    .s1_exp          (s1_exp),
    .s1_big          (s1_big),
    .s1_small        (s1_small),
    .s1_sticky       (s1_sticky),
    .s1_eff_sub      (s1_eff_sub),
    .s1_rmode        (s1_rmode),
    .s1_spec         (s1_spec),
    .s1_spec_word    (s1_spec_word),
    .s1_spec_invalid (s1_spec_invalid)
  );

  fadd_sum fadd_sum_i (
    .clk             (clk),
    .rst             (rst),
    .s1_valid        (s1_valid),
    .s1_sign         (s1_sign),
    .s1_exp          (s1_exp),
    .s1_big          (s1_big),
    .s1_small        (s1_small),
    .s1_sticky       (s1_sticky),
    .s1_eff_sub      (s1_eff_sub),
    .s1_rmode        (s1_rmode),
    .s1_spec         (s1_spec),
    .s1_spec_word    (s1_spec_word),
    .s1_spec_invalid (s1_spec_invalid),
    .s2_valid        (s2_valid),
    .s2_sign         (s2_sign),
    .s2_exp          (s2_exp),
    .s2_mant         (s2_mant),
    .s2_sticky       (s2_sticky),
    .s2_zero         (s2_zero),
    .s2_rmode        (s2_rmode),
    .s2_spec         (s2_spec),
    .s2_spec_word    (s2_spec_word),
    .s2_spec_invalid (s2_spec_invalid)
  );

  fadd_round fadd_round_i (
    .clk             (clk),
    .rst             (rst),
    .s2_valid        (s2_valid),
    .s2_sign         (s2_sign),
    .s2_exp          (s2_exp),
    .s2_mant         (s2_mant),
    .s2_sticky       (s2_sticky),
    .s2_zero         (s2_zero),
    .s2_rmode        (s2_rmode),
    .s2_spec         (s2_spec),
    .s2_spec_word    (s2_spec_word),
    .s2_spec_invalid (s2_spec_invalid),
    .res             (res),
    .res_valid       (res_valid),
    .raise           (raise)
  );

endmodule
